//--- hw/sun2_mmu_settings.svh
// --------------------
// Sun-2 MMU widths, map sizes and control-space register indexes
// --------------------
`ifndef SUN2_MMU_SETTINGS_SVH
`define SUN2_MMU_SETTINGS_SVH

// Bus and address widths
`define SUN2_DATA_W      16
`define SUN2_VADDR_W     23
`define SUN2_PADDR_W     22
`define SUN2_CTX_W       3
`define SUN2_SEG_IDX_W   9
`define SUN2_PMEG_W      8
`define SUN2_PAGE_IDX_W  4
`define SUN2_PFN_W       12
`define SUN2_PROT_W      6
`define SUN2_ENABLE_W    8

// Map depths
`define SUN2_SMAP_DEPTH  4096
`define SUN2_PMAP_DEPTH  4096

// Control space, A3 low, selected by A2,A1
`define SUN2_CREG_PMAP0    2'd0
`define SUN2_CREG_PMAP1    2'd1
`define SUN2_CREG_SMAP     2'd2
`define SUN2_CREG_CONTEXT  2'd3
// Control space, A3 high
`define SUN2_CREG_IDPROM   2'd0
`define SUN2_CREG_DIAG     2'd1
`define SUN2_CREG_ERROR    2'd2
`define SUN2_CREG_ENABLE   2'd3

`define SUN2_FC_CONTROL  3
`define SUN2_RESP_CYCLES 3

`endif

//--- hw/sun2_mmu_pkg.sv
// --------------------
// Sun-2 MMU shared types
// --------------------
`include "sun2_mmu_settings.svh"

package sun2_mmu_pkg;

   // Virtual word address, bits 23..1
   typedef logic [23:1] vaddr_t;
   // Physical word address, bits 22..1
   typedef logic [22:1] paddr_t;

   typedef logic [`SUN2_DATA_W-1:0]     word_t;
   typedef logic [`SUN2_CTX_W-1:0]      ctx_t;
   typedef logic [`SUN2_PMEG_W-1:0]     pmeg_t;
   typedef logic [`SUN2_PFN_W-1:0]      pfn_t;
   typedef logic [`SUN2_PROT_W-1:0]     prot_t;
   typedef logic [1:0]                  pte_type_t;
   typedef logic [2:0]                  fc_t;

   // Register select for one bus cycle
   typedef enum logic [3:0]
   {
      PMAP0,
      PMAP1,
      SMAP,
      CONTEXT,
      IDPROM,
      ERROR,
      ENABLE,
      DIAG,
      TRANSLATE
   } mmu_reg_t;

   typedef enum logic [1:0]
   {
      IDLE,
      LOOKUP,
      CHECK,
      RESPOND
   } cycle_state_t;

endpackage

//--- hw/cycle_decode.sv
// --------------------
// Bus cycle intake
// Latches a cycle, classifies it and steps it through the pipeline
// --------------------
`include "sun2_mmu_settings.svh"

module cycle_decode (
   input  logic                       C_S5,
   input  logic                       P_RESET_n,
   input  logic                       cyc,
   input  sun2_mmu_pkg::fc_t          fc,
   input  sun2_mmu_pkg::vaddr_t       vaddr,
   input  logic                       write,
   input  logic                       uds,
   input  logic                       lds,
   input  sun2_mmu_pkg::word_t        wdata,
   output sun2_mmu_pkg::cycle_state_t state,
   output sun2_mmu_pkg::mmu_reg_t     req_reg,
   output sun2_mmu_pkg::fc_t          req_fc,
   output sun2_mmu_pkg::vaddr_t       req_vaddr,
   output logic                       req_write,
   output logic                       req_uds,
   output logic                       req_lds,
   output sun2_mmu_pkg::word_t        req_wdata
);

   sun2_mmu_pkg::mmu_reg_t reg_sel;
   logic                   accept;

   assign accept = cyc && (state == sun2_mmu_pkg::IDLE);

   // --------------------
   // Control space decode
   always_comb
   begin
      reg_sel = sun2_mmu_pkg::IDPROM;
      if (fc != sun2_mmu_pkg::fc_t'(`SUN2_FC_CONTROL))
         reg_sel = sun2_mmu_pkg::TRANSLATE;
      else if (!vaddr[3])
      begin
         case (vaddr[2:1])
            `SUN2_CREG_PMAP0: reg_sel = sun2_mmu_pkg::PMAP0;
            `SUN2_CREG_PMAP1: reg_sel = sun2_mmu_pkg::PMAP1;
            `SUN2_CREG_SMAP:  reg_sel = sun2_mmu_pkg::SMAP;
            default:          reg_sel = sun2_mmu_pkg::CONTEXT;
         endcase
      end
      else if (write)
      begin
         if (vaddr[2:1] == `SUN2_CREG_DIAG)
            reg_sel = sun2_mmu_pkg::DIAG;
         else if (vaddr[2:1] == `SUN2_CREG_ENABLE)
            reg_sel = sun2_mmu_pkg::ENABLE;
      end
      else
      begin
         if (vaddr[2:1] == `SUN2_CREG_ERROR)
            reg_sel = sun2_mmu_pkg::ERROR;
         else if (vaddr[2:1] == `SUN2_CREG_ENABLE)
            reg_sel = sun2_mmu_pkg::ENABLE;
      end
      // Null accesses fall to IDPROM: zero data, nothing written
   end

   // --------------------
   // Sequencer
   always_ff @(posedge C_S5 or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
         state <= sun2_mmu_pkg::IDLE;
      else
      begin
         case (state)
            sun2_mmu_pkg::IDLE:
            begin
               if (cyc)
                  state <= sun2_mmu_pkg::LOOKUP;
            end
            sun2_mmu_pkg::LOOKUP:  state <= sun2_mmu_pkg::CHECK;
            sun2_mmu_pkg::CHECK:   state <= sun2_mmu_pkg::RESPOND;
            default:               state <= sun2_mmu_pkg::IDLE;
         endcase
      end
   end

   // Request held steady until the next accepted cycle
   always_ff @(posedge C_S5)
   begin
      if (accept)
      begin
         req_reg   <= reg_sel;
         req_fc    <= fc;
         req_vaddr <= vaddr;
         req_write <= write;
         req_uds   <= uds;
         req_lds   <= lds;
         req_wdata <= wdata;
      end
   end

endmodule

//--- hw/map_lookup.sv
// --------------------
// Context register, segment and page maps
// Translation lookup, protection check and statistics bits
// --------------------
`include "sun2_mmu_settings.svh"

module map_lookup (
   input  logic                       C_S5,
   input  logic                       P_RESET_n,
   input  sun2_mmu_pkg::cycle_state_t state,
   input  sun2_mmu_pkg::mmu_reg_t     req_reg,
   input  sun2_mmu_pkg::fc_t          req_fc,
   input  sun2_mmu_pkg::vaddr_t       req_vaddr,
   input  logic                       req_write,
   input  logic                       req_uds,
   input  logic                       req_lds,
   input  sun2_mmu_pkg::word_t        req_wdata,
   output sun2_mmu_pkg::word_t        map_rdata,
   output sun2_mmu_pkg::pfn_t         pfn,
   output sun2_mmu_pkg::pte_type_t    pa_type_q,
   output logic                       fault_invalid,
   output logic                       fault_prot
);

   localparam int SMAP_AW = `SUN2_CTX_W + `SUN2_SEG_IDX_W;
   localparam int PMAP_AW = `SUN2_PMEG_W + `SUN2_PAGE_IDX_W;

   sun2_mmu_pkg::pmeg_t smap  [`SUN2_SMAP_DEPTH];
   sun2_mmu_pkg::word_t pmap0 [`SUN2_PMAP_DEPTH];
   sun2_mmu_pkg::pfn_t  pmap1 [`SUN2_PMAP_DEPTH];

   sun2_mmu_pkg::ctx_t  user_ctx;
   sun2_mmu_pkg::ctx_t  super_ctx;
   sun2_mmu_pkg::ctx_t  ctx_sel;
   logic [SMAP_AW-1:0]  smap_idx;
   logic [PMAP_AW-1:0]  pmap_idx;
   sun2_mmu_pkg::pmeg_t seg_q;
   sun2_mmu_pkg::word_t pme0_rd;
   sun2_mmu_pkg::word_t pme0_q;
   sun2_mmu_pkg::word_t pme0_next;
   sun2_mmu_pkg::word_t rd_word;
   sun2_mmu_pkg::pfn_t  pfn_next;
   sun2_mmu_pkg::prot_t prot;
   logic                is_xlate;
   logic                respond;
   logic                allowed;
   logic                smap_we;
   logic                pme0_we;
   logic                pmap1_we;

   assign is_xlate = (req_reg == sun2_mmu_pkg::TRANSLATE);
   assign respond  = (state == sun2_mmu_pkg::RESPOND);
   // Supervisor half only for translated supervisor cycles
   assign ctx_sel  = (is_xlate && req_fc[2]) ? super_ctx : user_ctx;
   assign smap_idx = {ctx_sel, req_vaddr[23:15]};
   assign pmap_idx = {seg_q, req_vaddr[14:11]};
   assign pme0_rd  = pmap0[pmap_idx];
   assign prot     = pme0_rd[14:9];

   // Protection index is fc2, fc1, write
   always_comb
   begin
      case ({req_fc[2], req_fc[1], req_write})
         3'd0:    allowed = prot[2];
         3'd1:    allowed = prot[1];
         3'd2:    allowed = prot[0];
         3'd4:    allowed = prot[5];
         3'd5:    allowed = prot[4];
         3'd6:    allowed = prot[3];
         default: allowed = 1'b0;
      endcase
   end

   always_comb
   begin
      case (req_reg)
         sun2_mmu_pkg::PMAP0:   rd_word = {pme0_rd[15:4], 4'b0};
         sun2_mmu_pkg::PMAP1:   rd_word = sun2_mmu_pkg::word_t'(pmap1[pmap_idx]);
         sun2_mmu_pkg::SMAP:    rd_word = sun2_mmu_pkg::word_t'(seg_q);
         sun2_mmu_pkg::CONTEXT: rd_word = {5'b0, super_ctx, 5'b0, user_ctx};
         default:               rd_word = '0;
      endcase
   end

   // --------------------
   // Lookup and check stages
   always_ff @(posedge C_S5)
   begin
      if (state == sun2_mmu_pkg::LOOKUP)
         seg_q <= smap[smap_idx];
      if (state == sun2_mmu_pkg::CHECK)
      begin
         pme0_q    <= pme0_rd;
         pfn       <= pmap1[pmap_idx];
         pa_type_q <= pme0_rd[7:6];
         map_rdata <= rd_word;
      end
   end

   always_ff @(posedge C_S5 or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         fault_invalid <= 1'b0;
         fault_prot    <= 1'b0;
      end
      else if (state == sun2_mmu_pkg::CHECK)
      begin
         fault_invalid <= is_xlate && !pme0_rd[15];
         fault_prot    <= is_xlate && !allowed;
      end
   end

   // --------------------
   // Write back: byte merges and statistics
   always_comb
   begin
      pme0_next = pme0_q;
      pfn_next  = pfn;
      if (is_xlate)
      begin
         pme0_next[5] = 1'b1;
         pme0_next[4] = pme0_q[4] | req_write;
      end
      else
      begin
         if (req_uds)
         begin
            pme0_next[15:8] = req_wdata[15:8];
            pfn_next[11:8]  = req_wdata[11:8];
         end
         if (req_lds)
         begin
            pme0_next[7:4] = req_wdata[7:4];
            pfn_next[7:0]  = req_wdata[7:0];
         end
      end
   end

   assign smap_we  = respond && req_write && req_lds && (req_reg == sun2_mmu_pkg::SMAP);
   assign pmap1_we = respond && req_write && (req_reg == sun2_mmu_pkg::PMAP1);
   assign pme0_we  = respond &&
                     ((req_write && (req_reg == sun2_mmu_pkg::PMAP0)) ||
                      (is_xlate && !fault_invalid && !fault_prot));

   always_ff @(posedge C_S5)
   begin
      if (smap_we)
         smap[smap_idx] <= req_wdata[7:0];
      if (pme0_we)
         pmap0[pmap_idx] <= pme0_next;
      if (pmap1_we)
         pmap1[pmap_idx] <= pfn_next;
   end

   always_ff @(posedge C_S5 or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         user_ctx  <= '0;
         super_ctx <= '0;
      end
      else if (respond && req_write && (req_reg == sun2_mmu_pkg::CONTEXT))
      begin
         if (req_uds)
            super_ctx <= req_wdata[10:8];
         if (req_lds)
            user_ctx <= req_wdata[2:0];
      end
   end

endmodule

//--- hw/bus_response.sv
// --------------------
// Bus response
// Error, enable and diagnostic registers, DTACK/BERR and physical address
// --------------------
`include "sun2_mmu_settings.svh"

module bus_response (
   input  logic                       C_S5,
   input  logic                       P_RESET_n,
   input  sun2_mmu_pkg::cycle_state_t state,
   input  sun2_mmu_pkg::mmu_reg_t     req_reg,
   input  sun2_mmu_pkg::vaddr_t       req_vaddr,
   input  logic                       req_write,
   input  logic                       req_lds,
   input  sun2_mmu_pkg::word_t        req_wdata,
   input  sun2_mmu_pkg::word_t        map_rdata,
   input  sun2_mmu_pkg::pfn_t         pfn,
   input  sun2_mmu_pkg::pte_type_t    pa_type_q,
   input  logic                       fault_invalid,
   input  logic                       fault_prot,
   output sun2_mmu_pkg::word_t        rdata,
   output logic                       dtack,
   output logic                       berr,
   output sun2_mmu_pkg::paddr_t       pa,
   output sun2_mmu_pkg::pte_type_t    pa_type,
   output logic                       pa_strobe,
   output logic [`SUN2_ENABLE_W-1:0]  enable_bits,
   output logic [`SUN2_ENABLE_W-1:0]  diag_leds
);

   logic [1:0]          err_bits;
   logic                respond;
   logic                fault;
   logic                xlate_ok;
   sun2_mmu_pkg::word_t rd_sel;

   assign respond  = (state == sun2_mmu_pkg::RESPOND);
   assign fault    = fault_invalid | fault_prot;
   assign xlate_ok = (req_reg == sun2_mmu_pkg::TRANSLATE) && !fault;

   // Read data select
   always_comb
   begin
      case (req_reg)
         sun2_mmu_pkg::PMAP0,
         sun2_mmu_pkg::PMAP1,
         sun2_mmu_pkg::SMAP,
         sun2_mmu_pkg::CONTEXT: rd_sel = map_rdata;
         sun2_mmu_pkg::ERROR:   rd_sel = {{(`SUN2_DATA_W-2){1'b0}}, err_bits};
         sun2_mmu_pkg::ENABLE:  rd_sel = sun2_mmu_pkg::word_t'(enable_bits);
         default:               rd_sel = '0;
      endcase
   end

   // --------------------
   // Handshake and strobe
   always_ff @(posedge C_S5 or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         dtack     <= 1'b0;
         berr      <= 1'b0;
         pa_strobe <= 1'b0;
      end
      else
      begin
         dtack     <= respond && !fault;
         berr      <= respond && fault;
         pa_strobe <= respond && xlate_ok;
      end
   end

   always_ff @(posedge C_S5)
   begin
      if (respond)
         rdata <= req_write ? '0 : rd_sel;
      if (respond && xlate_ok)
      begin
         pa      <= {pfn, req_vaddr[10:1]};
         pa_type <= pa_type_q;
      end
   end

   // --------------------
   // Error, enable and diagnostic registers
   always_ff @(posedge C_S5 or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         err_bits    <= '0;
         enable_bits <= '0;
         diag_leds   <= '0;
      end
      else if (respond)
      begin
         if (fault)
            err_bits <= {fault_prot, fault_invalid};
         if (req_write && req_lds && (req_reg == sun2_mmu_pkg::ENABLE))
            enable_bits <= req_wdata[7:0];
         if (req_write && req_lds && (req_reg == sun2_mmu_pkg::DIAG))
            diag_leds <= req_wdata[7:0];
      end
   end

endmodule

//--- hw/sun2_mmu_top.sv
// --------------------
// Sun-2 MMU top level
// --------------------
`include "sun2_mmu_settings.svh"

module sun2_mmu_top (
   input  logic                       C_S5,
   input  logic                       P_RESET_n,
   input  logic                       cyc,
   input  sun2_mmu_pkg::fc_t          fc,
   input  sun2_mmu_pkg::vaddr_t       vaddr,
   input  logic                       write,
   input  logic                       uds,
   input  logic                       lds,
   input  sun2_mmu_pkg::word_t        wdata,
   output sun2_mmu_pkg::word_t        rdata,
   output logic                       dtack,
   output logic                       berr,
   output sun2_mmu_pkg::paddr_t       pa,
   output sun2_mmu_pkg::pte_type_t    pa_type,
   output logic                       pa_strobe,
   output logic [`SUN2_ENABLE_W-1:0]  enable_bits,
   output logic [`SUN2_ENABLE_W-1:0]  diag_leds
);

   sun2_mmu_pkg::cycle_state_t state;
   sun2_mmu_pkg::mmu_reg_t     req_reg;
   sun2_mmu_pkg::fc_t          req_fc;
   sun2_mmu_pkg::vaddr_t       req_vaddr;
   logic                       req_write;
   logic                       req_uds;
   logic                       req_lds;
   sun2_mmu_pkg::word_t        req_wdata;
   sun2_mmu_pkg::word_t        map_rdata;
   sun2_mmu_pkg::pfn_t         pfn;
   sun2_mmu_pkg::pte_type_t    pa_type_q;
   logic                       fault_invalid;
   logic                       fault_prot;

   cycle_decode u_decode (
      .C_S5      (C_S5),
      .P_RESET_n (P_RESET_n),
      .cyc       (cyc),
      .fc        (fc),
      .vaddr     (vaddr),
      .write     (write),
      .uds       (uds),
      .lds       (lds),
      .wdata     (wdata),
      .state     (state),
      .req_reg   (req_reg),
      .req_fc    (req_fc),
      .req_vaddr (req_vaddr),
      .req_write (req_write),
      .req_uds   (req_uds),
      .req_lds   (req_lds),
      .req_wdata (req_wdata)
   );

   map_lookup u_lookup (
      .C_S5          (C_S5),
      .P_RESET_n     (P_RESET_n),
      .state         (state),
      .req_reg       (req_reg),
      .req_fc        (req_fc),
      .req_vaddr     (req_vaddr),
      .req_write     (req_write),
      .req_uds       (req_uds),
      .req_lds       (req_lds),
      .req_wdata     (req_wdata),
      .map_rdata     (map_rdata),
      .pfn           (pfn),
      .pa_type_q     (pa_type_q),
      .fault_invalid (fault_invalid),
      .fault_prot    (fault_prot)
   );

   bus_response u_response (
      .C_S5          (C_S5),
      .P_RESET_n     (P_RESET_n),
      .state         (state),
      .req_reg       (req_reg),
      .req_vaddr     (req_vaddr),
      .req_write     (req_write),
      .req_lds       (req_lds),
      .req_wdata     (req_wdata),
      .map_rdata     (map_rdata),
      .pfn           (pfn),
      .pa_type_q     (pa_type_q),
      .fault_invalid (fault_invalid),
      .fault_prot    (fault_prot),
      .rdata         (rdata),
      .dtack         (dtack),
      .berr          (berr),
      .pa            (pa),
      .pa_type       (pa_type),
      .pa_strobe     (pa_strobe),
      .enable_bits   (enable_bits),
      .diag_leds     (diag_leds)
   );

endmodule

//--- verif/tb_clock_gen.sv
// --------------------
// Testbench clock and reset
// --------------------
module tb_clock_gen (
   output logic C_S5,
   output logic P_RESET_n
);

   initial
   begin
      C_S5 = 1'b0;
      forever
         #10 C_S5 = ~C_S5;
   end

   // Reset held for 8 clock cycles
   initial
   begin
      P_RESET_n = 1'b0;
      repeat (8) @(posedge C_S5);
      P_RESET_n <= 1'b1;
   end

endmodule

//--- verif/sun2_mmu_tb.sv
// --------------------
// Sun-2 MMU testbench
// Drives bus cycles, predicts each response and compares it
// --------------------
`include "sun2_mmu_settings.svh"

module sun2_mmu_tb;

   localparam int NUM_CYCLES = 127;

   logic C_S5, P_RESET_n, cyc, write, uds, lds, dtack, berr, pa_strobe;
   sun2_mmu_pkg::fc_t       fc;
   sun2_mmu_pkg::vaddr_t    vaddr;
   sun2_mmu_pkg::word_t     wdata, rdata;
   sun2_mmu_pkg::paddr_t    pa;
   sun2_mmu_pkg::pte_type_t pa_type;
   logic [7:0]              enable_bits, diag_leds;

   // Model state
   logic [7:0]          m_smap [4096];
   sun2_mmu_pkg::word_t m_pme0 [4096];
   sun2_mmu_pkg::pfn_t  m_pfn  [4096];
   sun2_mmu_pkg::ctx_t  m_usr, m_sup;
   logic [1:0]          m_err;
   logic [7:0]          m_enable, m_diag;

   // Expected and observed response of the last cycle
   string                   cur_name;
   sun2_mmu_pkg::word_t     exp_rdata, act_rdata;
   sun2_mmu_pkg::paddr_t    exp_pa, act_pa;
   sun2_mmu_pkg::pte_type_t exp_type, act_type;
   logic                    exp_fault, exp_strobe, act_dtack, act_berr, act_strobe;
   int                      act_edges;
   event                    resp_ev;
   logic [16:0]             lfsr_q = 17'd90675;

   logic [8:0] seg [4];
   logic [7:0] pmeg [4];
   logic [3:0] page;

   tb_clock_gen u_clk (.C_S5(C_S5), .P_RESET_n(P_RESET_n));

   sun2_mmu_top DUT (
      .C_S5(C_S5), .P_RESET_n(P_RESET_n), .cyc(cyc), .fc(fc), .vaddr(vaddr),
      .write(write), .uds(uds), .lds(lds), .wdata(wdata), .rdata(rdata),
      .dtack(dtack), .berr(berr), .pa(pa), .pa_type(pa_type), .pa_strobe(pa_strobe),
      .enable_bits(enable_bits), .diag_leds(diag_leds)
   );

   // 17-bit Fibonacci LFSR, x^17 + x^14 + 1, one step per bit
   function automatic logic [31:0] next_random(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr_q = {lfsr_q[15:0], lfsr_q[16] ^ lfsr_q[13]};
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic sun2_mmu_pkg::vaddr_t ctl_addr(input logic [8:0] s, input logic [2:0] r);
      return {s, page, 7'b0, r};
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   // --------------------
   // Reference function
   function automatic void predict(input sun2_mmu_pkg::fc_t f, input sun2_mmu_pkg::vaddr_t va,
                                   input logic wr, output sun2_mmu_pkg::word_t rd,
                                   output sun2_mmu_pkg::paddr_t p,
                                   output sun2_mmu_pkg::pte_type_t t,
                                   output logic flt, output logic strb,
                                   output logic [1:0] fbits);
      logic [11:0]         sidx;
      logic [11:0]         pidx;
      sun2_mmu_pkg::word_t pe;
      logic                ok;
      rd = '0;
      p = '0;
      t = '0;
      strb = 1'b0;
      fbits = 2'b00;
      sidx = {(f[2] && f != 3'd3) ? m_sup : m_usr, va[23:15]};
      pidx = {m_smap[sidx], va[14:11]};
      pe = m_pme0[pidx];
      if (f == 3'd3)
      begin
         if (!wr && !va[3])
         begin
            case (va[2:1])
               2'd0: rd = pe;
               2'd1: rd = {4'b0, m_pfn[pidx]};
               2'd2: rd = {8'b0, m_smap[sidx]};
               default: rd = {5'b0, m_sup, 5'b0, m_usr};
            endcase
         end
         else if (!wr && va[2:1] == 2'd2)
            rd = {14'b0, m_err};
         else if (!wr && va[2:1] == 2'd3)
            rd = {8'b0, m_enable};
      end
      else
      begin
         // Protection bits sit at pe[14:9]
         case ({f[2], f[1], wr})
            3'd0: ok = pe[11];
            3'd1: ok = pe[10];
            3'd2: ok = pe[9];
            3'd4: ok = pe[14];
            3'd5: ok = pe[13];
            3'd6: ok = pe[12];
            default: ok = 1'b0;
         endcase
         fbits = {!ok, !pe[15]};
         if (fbits == 2'b00)
         begin
            strb = 1'b1;
            p = {m_pfn[pidx], va[10:1]};
            t = pe[7:6];
         end
      end
      flt = |fbits;
   endfunction

   task automatic update_model(input sun2_mmu_pkg::fc_t f, input sun2_mmu_pkg::vaddr_t va,
                               input logic wr, input logic u, input logic l,
                               input sun2_mmu_pkg::word_t wd, input logic [1:0] fbits);
      logic [11:0] sidx;
      logic [11:0] pidx;
      sidx = {(f[2] && f != 3'd3) ? m_sup : m_usr, va[23:15]};
      pidx = {m_smap[sidx], va[14:11]};
      if (f != 3'd3)
      begin
         if (fbits != 2'b00)
            m_err = fbits;
         else
         begin
            m_pme0[pidx][5] = 1'b1;
            m_pme0[pidx][4] = m_pme0[pidx][4] | wr;
         end
      end
      else if (wr && !va[3])
      begin
         case (va[2:1])
            2'd0:
            begin
               if (u) m_pme0[pidx][15:8] = wd[15:8];
               if (l) m_pme0[pidx][7:4] = wd[7:4];
            end
            2'd1:
            begin
               if (u) m_pfn[pidx][11:8] = wd[11:8];
               if (l) m_pfn[pidx][7:0] = wd[7:0];
            end
            2'd2: if (l) m_smap[sidx] = wd[7:0];
            default:
            begin
               if (u) m_sup = wd[10:8];
               if (l) m_usr = wd[2:0];
            end
         endcase
      end
      else if (wr && l && va[2:1] == 2'd3)
         m_enable = wd[7:0];
      else if (wr && l && va[2:1] == 2'd1)
         m_diag = wd[7:0];
   endtask

   task automatic bus_cycle(input string name, input sun2_mmu_pkg::fc_t f,
                            input sun2_mmu_pkg::vaddr_t va, input logic wr, input logic u,
                            input logic l, input sun2_mmu_pkg::word_t wd);
      logic [1:0] fbits;
      int         edges;
      @(posedge C_S5);
      cur_name = name;
      predict(f, va, wr, exp_rdata, exp_pa, exp_type, exp_fault, exp_strobe, fbits);
      cyc <= 1'b1;
      fc <= f;
      vaddr <= va;
      write <= wr;
      uds <= u;
      lds <= l;
      wdata <= wd;
      @(posedge C_S5);
      cyc <= 1'b0;
      edges = 0;
      while (!(dtack || berr))
      begin
         if (edges > 8)
            report_failure($sformatf("No dtack or berr for cycle %s", name));
         @(posedge C_S5);
         edges++;
         @(negedge C_S5);
      end
      act_edges = edges;
      act_rdata = rdata;
      act_pa = pa;
      act_type = pa_type;
      act_dtack = dtack;
      act_berr = berr;
      act_strobe = pa_strobe;
      -> resp_ev;
      update_model(f, va, wr, u, l, wd, fbits);
   endtask

   // --------------------
   // Response compare
   always @(resp_ev)
   begin
      assert (act_edges == `SUN2_RESP_CYCLES)
      else report_failure($sformatf("%s answered after %0d edges instead of %0d",
                                    cur_name, act_edges, `SUN2_RESP_CYCLES));
      assert (act_berr === exp_fault && act_dtack === !exp_fault)
      else report_failure($sformatf("%s got the wrong response type, expected %s",
                                    cur_name, exp_fault ? "berr" : "dtack"));
      assert (act_rdata === exp_rdata)
      else report_failure($sformatf("FAILED %s rdata: expected %h, actual %h",
                                    cur_name, exp_rdata, act_rdata));
      assert (act_strobe === exp_strobe)
      else report_failure($sformatf("FAILED %s pa_strobe: expected %b, actual %b",
                                    cur_name, exp_strobe, act_strobe));
      if (exp_strobe)
      begin
         assert (act_pa === exp_pa)
         else report_failure($sformatf("FAILED %s pa: expected %h, actual %h",
                                       cur_name, exp_pa, act_pa));
         assert (act_type === exp_type)
         else report_failure($sformatf("FAILED %s pa_type: expected %h, actual %h",
                                       cur_name, exp_type, act_type));
      end
   end

   initial
   begin
      #((NUM_CYCLES * 5 + 50) * 20);
      $display("Timeout, the test sequence did not finish in time");
      $display("CHECKS FAILED");
      $fatal(1);
   end

   // --------------------
   // Stimulus
   initial
   begin
      logic [1:0] k;
      logic [2:0] f;
      logic [2:0] b;
      cyc = 1'b0;
      fc = '0;
      vaddr = '0;
      write = 1'b0;
      uds = 1'b0;
      lds = 1'b0;
      wdata = '0;
      for (int i = 0; i < 4096; i++)
      begin
         m_smap[i] = '0;
         m_pme0[i] = '0;
         m_pfn[i] = '0;
      end
      m_usr = '0;
      m_sup = '0;
      m_err = '0;
      m_enable = '0;
      m_diag = '0;
      page = 4'(next_random(4));
      for (int i = 0; i < 4; i++)
      begin
         seg[i] = {7'(next_random(7)), 2'(i)};
         pmeg[i] = {6'(next_random(6)), 2'(i)};
      end

      @(posedge P_RESET_n);
      @(negedge C_S5);
      assert (!dtack && !berr && !pa_strobe && enable_bits == 8'h0 && diag_leds == 8'h0)
      else report_failure("Outputs not idle after reset");

      // Context halves must differ
      b = 3'(next_random(3));
      bus_cycle("ctx_write", 3, ctl_addr(0, 3), 1, 1, 1,
                {5'(next_random(5)), b ^ {2'(next_random(2)), 1'b1}, 5'(next_random(5)), b});
      bus_cycle("ctx_read", 3, ctl_addr(0, 3), 0, 0, 0, 0);

      for (int i = 0; i < 4; i++)
      begin
         bus_cycle("smap_write", 3, ctl_addr(seg[i], 2), 1, 1, 1,
                   {8'(next_random(8)), pmeg[i]});
         bus_cycle("smap_upper_write", 3, ctl_addr(seg[i], 2), 1, 1, 0,
                   16'(next_random(16)));
         bus_cycle("smap_read", 3, ctl_addr(seg[i], 2), 0, 0, 0, 0);
         bus_cycle("pmap0_write", 3, ctl_addr(seg[i], 0), 1, 1, 1, 16'(next_random(16)));
         bus_cycle("pmap1_write", 3, ctl_addr(seg[i], 1), 1, 1, 1, 16'(next_random(16)));
         bus_cycle("pmap0_strobe_write", 3, ctl_addr(seg[i], 0), 1, 1'(next_random(1)),
                   1'(next_random(1)), 16'(next_random(16)));
         bus_cycle("pmap1_strobe_write", 3, ctl_addr(seg[i], 1), 1, 1'(next_random(1)),
                   1'(next_random(1)), 16'(next_random(16)));
         bus_cycle("pmap0_read", 3, ctl_addr(seg[i], 0), 0, 0, 0, 0);
         bus_cycle("pmap1_read", 3, ctl_addr(seg[i], 1), 0, 0, 0, 0);
      end

      // Supervisor segments point to the neighbouring page map group
      bus_cycle("ctx_user_to_super", 3, ctl_addr(0, 3), 1, 0, 1, {13'b0, m_sup});
      for (int i = 0; i < 4; i++)
         bus_cycle("smap_super_write", 3, ctl_addr(seg[i], 2), 1, 1, 1, {8'b0, pmeg[i ^ 1]});
      bus_cycle("ctx_user_restore", 3, ctl_addr(0, 3), 1, 0, 1, {13'b0, b});
      bus_cycle("ctx_read_back", 3, ctl_addr(0, 3), 0, 0, 0, 0);

      // Group 0 fully permitted, group 1 invalid
      bus_cycle("pmap0_permit", 3, ctl_addr(seg[0], 0), 1, 1, 1, 16'hfe80);
      bus_cycle("pmap0_invalid", 3, ctl_addr(seg[1], 0), 1, 1, 1, 16'h7e40);
      for (int i = 0; i < 8; i++)
      begin
         k = i[0];
         f = (i < 2) ? 3'd1 : (i < 4) ? 3'd5 : (i < 6) ? 3'd2 : 3'd6;
         bus_cycle("xlate_fixed", f, {seg[k], page, 10'(next_random(10))}, i[1] ^ (i >= 4),
                   1, 1, 16'(next_random(16)));
         bus_cycle("error_read", 3, ctl_addr(0, 2) | 23'h4, 0, 0, 0, 0);
         bus_cycle("stats_read", 3, ctl_addr(seg[k], 0), 0, 0, 0, 0);
      end

      // Supervisor program write on a permitted page
      bus_cycle("xlate_prog_write", 6, {seg[1], page, 10'(next_random(10))}, 1,
                1, 1, 16'(next_random(16)));
      bus_cycle("error_read", 3, ctl_addr(0, 2) | 23'h4, 0, 0, 0, 0);

      for (int i = 0; i < 16; i++)
      begin
         k = 2'(next_random(2));
         f = 3'(next_random(3));
         if (f == 3'd3)
            f = 3'd5;
         bus_cycle("xlate_random", f, {seg[k], page, 10'(next_random(10))},
                   1'(next_random(1)), 1, 1, 16'(next_random(16)));
         bus_cycle("error_read", 3, ctl_addr(0, 2) | 23'h4, 0, 0, 0, 0);
         bus_cycle("stats_read", 3, ctl_addr(seg[k], 0), 0, 0, 0, 0);
      end

      bus_cycle("enable_write", 3, ctl_addr(0, 7), 1, 1, 1, 16'(next_random(16)));
      bus_cycle("enable_read", 3, ctl_addr(0, 7), 0, 0, 0, 0);
      bus_cycle("diag_write", 3, ctl_addr(0, 5), 1, 1, 1, 16'(next_random(16)));
      bus_cycle("idprom_read", 3, ctl_addr(0, 4), 0, 0, 0, 0);
      bus_cycle("null_write", 3, ctl_addr(0, 4), 1, 1, 1, 16'(next_random(16)));
      bus_cycle("null_read", 3, ctl_addr(0, 5), 0, 0, 0, 0);
      assert (enable_bits === m_enable)
      else report_failure($sformatf("FAILED enable_bits: expected %h, actual %h",
                                    m_enable, enable_bits));
      assert (diag_leds === m_diag)
      else report_failure($sformatf("FAILED diag_leds: expected %h, actual %h",
                                    m_diag, diag_leds));

      @(posedge C_S5);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- sim.f
+incdir+hw
hw/sun2_mmu_pkg.sv
hw/cycle_decode.sv
hw/map_lookup.sv
hw/bus_response.sv
hw/sun2_mmu_top.sv
verif/tb_clock_gen.sv
verif/sun2_mmu_tb.sv

//--- Bender.yml
package:
  name: sun2_mmu

sources:
  - include_dirs:
      - hw
    files:
      - hw/sun2_mmu_pkg.sv
      - hw/cycle_decode.sv
      - hw/map_lookup.sv
      - hw/bus_response.sv
      - hw/sun2_mmu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/tb_clock_gen.sv
      - verif/sun2_mmu_tb.sv
